//--- hw/counter_snapshot.sv
`include "perf_consts.svh"

// stage 3 of the monitor pipeline
// shadow bank for all counters plus a registered indexed read
//
// snap at edge s copies every live count as it stood before edge s
// rd_addr at edge r drives that shadow onto rd_data after edge r
// a read at the same edge as a snap still sees the older shadow

module counter_snapshot
	import perf_pkg::*;
(
	input logic clk,
	input logic rst_n,

	input count_t [`PERF_NUM_COUNTERS-1:0] counts, // live totals from the counters
	input logic snap, // pulse, freeze all counts together

	input counter_idx_t rd_addr, // which shadow to return
	output count_t rd_data // selected shadow, one cycle after rd_addr
);

	count_t shadow [`PERF_NUM_COUNTERS]; // frozen counts

	// all four load on the same edge
	// so a set of reads always comes from one consistent instant
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < `PERF_NUM_COUNTERS; i++) begin
				shadow[i] <= '0;
			end
		end else if (snap) begin
			for (int i = 0; i < `PERF_NUM_COUNTERS; i++) begin
				shadow[i] <= counts[i];
			end
		end
	end

	// read port
	// fixed single cycle latency, no valid strobe needed
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rd_data <= '0;
		end else begin
			rd_data <= shadow[rd_addr]; // shadow only changes on snap
		end
	end

	// counts lag the events by three edges
	// a snap therefore captures events sampled up to edge s-3
	// anything later stays in the live counters until the next snap

endmodule

//--- hw/event_tally.sv
`include "perf_consts.svh"

// stage 1 of the monitor pipeline
// reduces each group of strobes to a delta and lines it up with the enable

module event_tally
	import perf_pkg::*;
(
	input logic clk,
	input logic rst_n,

	input event_group_t [`PERF_NUM_COUNTERS-1:0] events, // group i in bits 7i+6..7i
	input logic count_en, // level, counting allowed this cycle

	output delta_t [`PERF_NUM_COUNTERS-1:0] deltas, // registered popcounts
	output logic tally_en // count_en delayed to match deltas
);

	// number of set strobes in one group
	function automatic delta_t popcount(input event_group_t grp);
		delta_t n;
		n = '0;
		for (int b = 0; b < `PERF_EVENTS_PER_COUNTER; b++) begin
			n = n + delta_t'(grp[b]); // 7 ones still fit in 3 bits
		end
		return n;
	endfunction

	delta_t tally_next [`PERF_NUM_COUNTERS]; // combinational counts, one per group

	always_comb begin
		for (int g = 0; g < `PERF_NUM_COUNTERS; g++) begin
			tally_next[g] = popcount(events[g]);
		end
	end

	// deltas load every cycle whatever count_en is
	// the counter stage uses tally_en to decide whether they are added
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int g = 0; g < `PERF_NUM_COUNTERS; g++) begin
				deltas[g] <= '0;
			end
		end else begin
			for (int g = 0; g < `PERF_NUM_COUNTERS; g++) begin
				deltas[g] <= tally_next[g];
			end
		end
	end

	// enable follows the same one-cycle path as the deltas
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			tally_en <= 1'b0; // inactive out of reset
		end else begin
			tally_en <= count_en;
		end
	end

endmodule

//--- hw/perf_consts.svh
`ifndef PERF_CONSTS_SVH
`define PERF_CONSTS_SVH

// number of counters, one per event group
`define PERF_NUM_COUNTERS 4

// event strobes that feed one counter
`define PERF_EVENTS_PER_COUNTER 7

// accumulator width (matches the DSP48 P output)
`define PERF_COUNT_WIDTH 48

// per-cycle increment wide enough for 0 to 7 set strobes
`define PERF_DELTA_WIDTH 3

// index that picks one counter on readout
`define PERF_IDX_WIDTH 2

`endif

//--- hw/perf_counter.sv
`include "perf_consts.svh"

// stage 2 of the monitor pipeline
// 48-bit accumulator in plain logic with the register layout of a DSP48 slice
// used as P <= P + C
//
// edge k+1   delta captured into delta_q when en is high (C register, CEC = en)
//            en copied into en_ff
// edge k+2   count <= count + delta_q when en_ff is high (P register, CEP = en_ff)
//
// so a delta presented before edge k+1 shows up on count after edge k+2
// counts wrap modulo 2^48

module perf_counter
	import perf_pkg::*;
(
	input logic clk,
	input logic rst_n,

	input logic clear, // pulse, zeroes the whole accumulate path
	input logic en, // delta is valid for counting
	input delta_t delta, // increment for this cycle

	output count_t count // running total (P register)
);

	delta_t delta_q; // captured increment (C register)
	logic en_ff; // en delayed one cycle, clock enable of the adder stage
	count_t delta_ext; // increment widened to the accumulator

	// C register and the delayed enable
	// clear wins over a new capture so nothing in flight survives it
	always_ff @(posedge clk) begin
		if (!rst_n || clear) begin
			delta_q <= '0;
			en_ff <= 1'b0;
		end else begin
			en_ff <= en;
			if (en) begin
				delta_q <= delta; // hold last value while disabled
			end
		end
	end

	// zero extend to 48 bits, upper bits of the C port tie low
	assign delta_ext = count_t'(delta_q);

	// P register
	// only advances on the cycle after an enabled capture
	always_ff @(posedge clk) begin
		if (!rst_n || clear) begin
			count <= '0;
		end else if (en_ff) begin
			count <= count + delta_ext; // z = 0, y = c, x = p
		end
	end

	// note that an event sampled at the clear edge reaches delta on the
	// following cycle, so it is captured after the clear and still counted
	// events one or two cycles older are sitting in delta_q or count and
	// get dropped along with the old total

endmodule

//--- hw/perf_monitor_top.sv
`include "perf_consts.svh"

// performance monitor
//
// events -> event_tally -> perf_counter x4 -> counter_snapshot -> rd_data
//
// the whole path accepts new events every cycle and nothing stalls
// an event becomes part of the live count three edges after it is sampled
// and is readable once a snap is sampled at least three edges later

module perf_monitor_top
	import perf_pkg::*;
(
	input logic clk,
	input logic rst_n,

	input event_group_t [`PERF_NUM_COUNTERS-1:0] events, // 4 x 7 strobes, flattened
	input logic count_en, // level enable for counting
	input logic clear, // pulse, zero all counters
	input logic snap, // pulse, freeze all counters

	input counter_idx_t rd_addr, // counter to read back
	output count_t rd_data // frozen count, one cycle after rd_addr
);

	delta_t [`PERF_NUM_COUNTERS-1:0] deltas; // per-group increments from stage 1
	logic tally_en; // enable aligned with deltas
	count_t [`PERF_NUM_COUNTERS-1:0] counts; // live totals from stage 2

	// stage 1
	event_tally u_tally (
		.clk (clk),
		.rst_n (rst_n),
		.events (events),
		.count_en (count_en),
		.deltas (deltas),
		.tally_en (tally_en)
	);

	// stage 2
	// one accumulator per event group, all sharing clear and enable
	for (genvar i = 0; i < `PERF_NUM_COUNTERS; i++) begin : g_counter
		perf_counter u_counter (
			.clk (clk),
			.rst_n (rst_n),
			.clear (clear),
			.en (tally_en),
			.delta (deltas[i]),
			.count (counts[i])
		);
	end

	// stage 3
	counter_snapshot u_snapshot (
		.clk (clk),
		.rst_n (rst_n),
		.counts (counts),
		.snap (snap),
		.rd_addr (rd_addr),
		.rd_data (rd_data)
	);

endmodule

//--- hw/perf_pkg.sv
`include "perf_consts.svh"

package perf_pkg;

	// one live or frozen counter value
	typedef logic [`PERF_COUNT_WIDTH-1:0] count_t;

	// popcount of one group in one cycle
	typedef logic [`PERF_DELTA_WIDTH-1:0] delta_t;

	// the strobes belonging to a single counter
	typedef logic [`PERF_EVENTS_PER_COUNTER-1:0] event_group_t;

	// selects a counter in the shadow bank
	typedef logic [`PERF_IDX_WIDTH-1:0] counter_idx_t;

	// group i sits in bits 7i+6..7i when packed as event_group_t [N-1:0]
	// deltas and counts are packed the same way, index i in element [i]

endpackage

//--- tb.f
+incdir+hw
hw/perf_pkg.sv
hw/event_tally.sv
hw/perf_counter.sv
hw/counter_snapshot.sv
hw/perf_monitor_top.sv
testbench/perf_monitor_tb.sv

//--- testbench/perf_monitor_tb.sv
`include "perf_consts.svh"

module perf_monitor_tb
	import perf_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int RESET_CYCLES = 10;
	localparam int RESET_TIMEOUT = 50; // cycles allowed for reset to release
	localparam int NC = `PERF_NUM_COUNTERS;

	logic clk;
	logic rst_n;
	event_group_t [NC-1:0] events;
	logic count_en;
	logic clear;
	logic snap;
	counter_idx_t rd_addr;
	count_t rd_data;

	logic rd_check; // this cycle's rd_addr is a read to compare
	count_t rd_exp; // value expected for that read

	logic [31:0] rng_state = 32'hce2d;
	int errors = 0;
	int checks = 0;

	// reference state
	count_t exp_acc [NC]; // live totals, events up to the latest edge
	count_t exp_d1 [NC]; // one edge old
	count_t exp_d2 [NC]; // two edges old, what a snap at the next edge captures
	count_t exp_shadow [NC];
	count_t frozen [NC]; // copy of the shadows right after a snap

	perf_monitor_top UUT (
		.clk (clk),
		.rst_n (rst_n),
		.events (events),
		.count_en (count_en),
		.clear (clear),
		.snap (snap),
		.rd_addr (rd_addr),
		.rd_data (rd_data)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk; // 4 ns period
	end

	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1 rst_n = 1'b1;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	function automatic logic [27:0] random_events();
		rng_state = xorshift32(rng_state);
		return rng_state[27:0]; // low 28 bits, one per strobe
	endfunction

	// set strobes in one group
	function automatic int group_popcount(input event_group_t grp);
		return $countones(grp);
	endfunction

	// expected counts follow the plain counting rules
	// clear at an edge drops everything older, the events at that edge still count
	// a snap copies the totals as they stood three edges back
	always @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < NC; i++) begin
				exp_acc[i] = '0;
				exp_d1[i] = '0;
				exp_d2[i] = '0;
				exp_shadow[i] = '0;
			end
		end else begin
			for (int i = 0; i < NC; i++) begin
				if (snap)
					exp_shadow[i] = exp_d2[i];
				exp_d2[i] = exp_d1[i];
				exp_d1[i] = exp_acc[i];
				if (clear) begin
					exp_acc[i] = '0;
					exp_d1[i] = '0; // older events never reach a later snap
					exp_d2[i] = '0;
				end
				if (count_en)
					exp_acc[i] = exp_acc[i] + count_t'(group_popcount(events[i]));
			end
		end
	end

	task automatic check_count(input counter_idx_t idx, input count_t actual,
		input count_t expected);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("MISMATCH rd_data[%0d]: got 0x%h expected 0x%h", idx, actual, expected);
		end
	endtask

	// read sampled at edge r, rd_data settled by the falling edge after it
	initial begin
		counter_idx_t idx;
		count_t expv;
		forever begin
			@(posedge clk);
			if (rd_check === 1'b1) begin
				idx = rd_addr;
				expv = rd_exp;
				@(negedge clk);
				check_count(idx, rd_data, expv);
			end
		end
	end

	// advance to 1 ns after the next rising edge and drop the pulses
	task automatic step();
		@(posedge clk);
		#1;
		clear = 1'b0;
		snap = 1'b0;
		rd_check = 1'b0;
	endtask

	task automatic random_cycles(input int n, input logic en);
		for (int c = 0; c < n; c++) begin
			events = random_events();
			count_en = en;
			step();
		end
	endtask

	task automatic issue_read(input counter_idx_t idx, input count_t expv);
		rd_addr = idx;
		rd_exp = expv;
		rd_check = 1'b1;
	endtask

	// snap with events still arriving at the given enable
	task automatic take_snapshot(input logic en);
		events = random_events();
		count_en = en;
		snap = 1'b1;
		step();
		for (int i = 0; i < NC; i++)
			frozen[i] = exp_shadow[i]; // model updated at the snap edge
	endtask

	task automatic read_all_model();
		for (int i = 0; i < NC; i++) begin
			issue_read(counter_idx_t'(i), exp_shadow[i]);
			step();
		end
	endtask

	initial begin
		int n;
		bit reset_ok;
		events = '0;
		count_en = 1'b0;
		clear = 1'b0;
		snap = 1'b0;
		rd_addr = '0;
		rd_check = 1'b0;
		rd_exp = '0;
		n = 0;
		reset_ok = 1'b1;

		while (rst_n !== 1'b1 && reset_ok) begin
			if (n >= RESET_TIMEOUT)
				reset_ok = 1'b0;
			@(posedge clk);
			#1;
			n++;
		end

		if (!reset_ok) begin
			errors++;
			$display("reset never released within %0d cycles", RESET_TIMEOUT);
		end else begin
			// 1: enabled random run, idle until the pipe drains, then snap
			random_cycles(200, 1'b1);
			random_cycles(3, 1'b0);
			take_snapshot(1'b0);
			read_all_model();

			// 2: disabled events must leave the snapshot as it was
			random_cycles(50, 1'b0);
			begin
				count_t prev [NC];
				for (int i = 0; i < NC; i++)
					prev[i] = frozen[i];
				take_snapshot(1'b0);
				for (int i = 0; i < NC; i++) begin
					issue_read(counter_idx_t'(i), prev[i]);
					step();
				end
			end

			// 3: clear partway, only events at or after the clear edge survive
			random_cycles(40, 1'b1);
			events = random_events();
			count_en = 1'b1;
			clear = 1'b1;
			step();
			random_cycles(60, 1'b1);
			random_cycles(3, 1'b0);
			take_snapshot(1'b0);
			read_all_model();

			// 4: reads stay frozen while counting goes on
			random_cycles(30, 1'b1);
			take_snapshot(1'b1);
			for (int r = 0; r < 3; r++) begin
				for (int i = 0; i < NC; i++) begin
					events = random_events();
					count_en = 1'b1;
					issue_read(counter_idx_t'(i), frozen[i]);
					step();
				end
			end
			random_cycles(20, 1'b1);
			random_cycles(3, 1'b0);
			take_snapshot(1'b0);
			read_all_model(); // new totals

			// 5: every strobe high, delta of 7 each cycle
			events = '1;
			count_en = 1'b1;
			clear = 1'b1;
			step();
			for (int c = 0; c < 99; c++) begin
				events = '1;
				count_en = 1'b1;
				step();
			end
			events = '0;
			count_en = 1'b0;
			repeat (3) step();
			snap = 1'b1;
			step();
			for (int i = 0; i < NC; i++) begin
				issue_read(counter_idx_t'(i), count_t'(700)); // 100 cycles x 7
				step();
			end

			repeat (4) step(); // let the last compare land
		end

		$display("perf_monitor_tb: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule
